//--- core_mem_pkg.sv
package core_mem_pkg;

	// lane and line geometry
	localparam int IDATA_WIDTH = 8;
	localparam int MAC_MULT_NUM = 16;
	localparam int LINE_WIDTH = IDATA_WIDTH * MAC_MULT_NUM;
	localparam int LANE_SEL_WIDTH = $clog2(MAC_MULT_NUM);

	// host side, one word spans two lanes
	localparam int HOST_DATA_WIDTH = 16;
	localparam int WORDS_PER_LINE = LINE_WIDTH / HOST_DATA_WIDTH;
	localparam int WORD_SEL_WIDTH = $clog2(WORDS_PER_LINE);
	localparam int HOST_ADDR_WIDTH = 14;
	localparam int HOST_REGION_WIDTH = 2;

	// core side address
	localparam int CMEM_ADDR_WIDTH = 12;
	localparam int KV_ENTRY_WIDTH = CMEM_ADDR_WIDTH - 1 - LANE_SEL_WIDTH;

	// users of the kv cache
	localparam int MAX_USERS = 4;
	localparam int USER_ID_WIDTH = $clog2(MAX_USERS);

	// widest sram address of either memory
	localparam int LINE_ADDR_WIDTH = 10;

	typedef logic [LINE_WIDTH-1:0] line_t;
	typedef logic [HOST_DATA_WIDTH-1:0] host_word_t;
	typedef logic [LINE_ADDR_WIDTH-1:0] line_addr_t;

	// one access to a line-wide sram
	typedef struct packed {
		logic       wen;
		logic       ren;
		line_addr_t addr;
		line_t      wdata;
		line_t      bwe;
	} mem_req_t;

	// core address as seen by weight memory
	typedef struct packed {
		logic                       kv;
		logic [CMEM_ADDR_WIDTH-2:0] line;
	} cmem_wgt_addr_t;

	// core address as seen by the kv cache
	typedef struct packed {
		logic                      kv;
		logic [LANE_SEL_WIDTH-1:0] bank;
		logic [KV_ENTRY_WIDTH-1:0] entry;
	} cmem_kv_addr_t;

	typedef union packed {
		cmem_wgt_addr_t wgt;
		cmem_kv_addr_t  kv;
	} cmem_addr_u;

endpackage

//--- sram_sp.sv
`timescale 1ns/100ps

module sram_sp #(
	parameter int DEPTH = 256
) (
	input  logic                   clk,
	input  core_mem_pkg::mem_req_t req,
	output core_mem_pkg::line_t    rdata
);
	import core_mem_pkg::*;

	localparam int AW = $clog2(DEPTH);

	line_t mem [DEPTH];
	logic [AW-1:0] addr;

	// only the low bits reach the array
	assign addr = req.addr[AW-1:0];

	// bit-masked write, unmasked bits keep their old value
	always_ff @(posedge clk) begin
		if (req.wen) begin
			mem[addr] <= (req.wdata & req.bwe) | (mem[addr] & ~req.bwe);
		end
	end

	// registered read, holds the last line between reads
	always_ff @(posedge clk) begin
		if (req.ren) begin
			rdata <= mem[addr];
		end
	end

endmodule

//--- host_bridge.sv
`timescale 1ns/100ps

module host_bridge (
	input  logic                                     clk,
	input  logic                                     rstn,
	input  logic [core_mem_pkg::HOST_ADDR_WIDTH-1:0] host_addr,
	input  core_mem_pkg::host_word_t                 host_wdata,
	input  logic                                     host_wen,
	input  logic                                     host_ren,
	output core_mem_pkg::mem_req_t                   wmem_host_req,
	output core_mem_pkg::mem_req_t                   kv_host_req,
	input  core_mem_pkg::line_t                      wmem_host_rdata,
	input  core_mem_pkg::line_t                      kv_cache_rdata,
	output core_mem_pkg::host_word_t                 host_rdata,
	output logic                                     host_rvld
);
	import core_mem_pkg::*;

	localparam int MID_W = HOST_ADDR_WIDTH - HOST_REGION_WIDTH - WORD_SEL_WIDTH;

	logic [HOST_REGION_WIDTH-1:0] region;
	logic [MID_W-1:0] mid_line;
	logic [WORD_SEL_WIDTH-1:0] word_sel;
	logic region_kv;
	logic [HOST_REGION_WIDTH+MID_W-1:0] wgt_line;
	line_addr_t line_addr;
	line_t slice_data;
	line_t slice_bwe;

	logic wgt_wen_q;
	logic wgt_ren_q;
	logic kv_wen_q;
	logic kv_ren_q;
	line_addr_t addr_q;
	line_t wdata_q;
	line_t bwe_q;

	logic ren_d1;
	logic [WORD_SEL_WIDTH-1:0] word_d1;
	logic [WORD_SEL_WIDTH-1:0] word_d2;
	logic kv_d1;
	logic kv_d2;
	line_t ret_line;

	// address split and line packing
	always_comb begin
		region = host_addr[HOST_ADDR_WIDTH-1 -: HOST_REGION_WIDTH];
		mid_line = host_addr[WORD_SEL_WIDTH +: MID_W];
		word_sel = host_addr[WORD_SEL_WIDTH-1:0];
		region_kv = (region == '0);
		// weight regions start at 1, so shift them down by one
		wgt_line = {region - HOST_REGION_WIDTH'(1), mid_line};
		line_addr = region_kv ? line_addr_t'(mid_line) : line_addr_t'(wgt_line);
		slice_data = '0;
		slice_bwe = '0;
		slice_data[word_sel*HOST_DATA_WIDTH +: HOST_DATA_WIDTH] = host_wdata;
		slice_bwe[word_sel*HOST_DATA_WIDTH +: HOST_DATA_WIDTH] = '1;
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			wgt_wen_q <= 1'b0;
			wgt_ren_q <= 1'b0;
			kv_wen_q <= 1'b0;
			kv_ren_q <= 1'b0;
		end else begin
			wgt_wen_q <= host_wen && !region_kv;
			wgt_ren_q <= host_ren && !region_kv;
			kv_wen_q <= host_wen && region_kv;
			kv_ren_q <= host_ren && region_kv;
		end
	end

	// one payload serves both buses, only one of them is enabled
	always_ff @(posedge clk) begin
		if (host_wen || host_ren) begin
			addr_q <= line_addr;
			wdata_q <= slice_data;
			bwe_q <= slice_bwe;
		end
	end

	always_comb begin
		wmem_host_req.wen = wgt_wen_q;
		wmem_host_req.ren = wgt_ren_q;
		wmem_host_req.addr = addr_q;
		wmem_host_req.wdata = wdata_q;
		wmem_host_req.bwe = bwe_q;
		kv_host_req.wen = kv_wen_q;
		kv_host_req.ren = kv_ren_q;
		kv_host_req.addr = addr_q;
		kv_host_req.wdata = wdata_q;
		kv_host_req.bwe = bwe_q;
	end

	// read valid lines up with the sram output two cycles later
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			ren_d1 <= 1'b0;
			host_rvld <= 1'b0;
		end else begin
			ren_d1 <= host_ren;
			host_rvld <= ren_d1;
		end
	end

	always_ff @(posedge clk) begin
		word_d1 <= word_sel;
		word_d2 <= word_d1;
		kv_d1 <= region_kv;
		kv_d2 <= kv_d1;
	end

	// pick the answering memory, then the word inside its line
	always_comb begin
		ret_line = kv_d2 ? kv_cache_rdata : wmem_host_rdata;
		host_rdata = ret_line[word_d2*HOST_DATA_WIDTH +: HOST_DATA_WIDTH];
	end

endmodule

//--- weight_mem.sv
`timescale 1ns/100ps

module weight_mem #(
	parameter int DEPTH = 256
) (
	input  logic                   clk,
	input  core_mem_pkg::mem_req_t host_req,
	input  core_mem_pkg::mem_req_t core_req,
	output core_mem_pkg::line_t    rdata
);
	import core_mem_pkg::*;

	mem_req_t sram_req;
	logic host_act;

	// host wins, a core access in the same cycle is lost
	assign host_act = host_req.wen || host_req.ren;

	always_comb begin
		if (host_act) begin
			sram_req = host_req;
		end else begin
			sram_req = core_req;
		end
	end

	// rdata goes to both the host bridge and the core port
	sram_sp #(
		.DEPTH(DEPTH)
	) u_sram (
		.clk  (clk),
		.req  (sram_req),
		.rdata(rdata)
	);

endmodule

//--- kv_clean_seq.sv
`timescale 1ns/100ps

module kv_clean_seq #(
	parameter int KV_USER_DEPTH = 64,
	parameter int NUM_USERS = 4
) (
	input  logic                                   clk,
	input  logic                                   rstn,
	input  logic                                   clean_kv_cache,
	input  logic [core_mem_pkg::USER_ID_WIDTH-1:0] clean_user_id,
	output logic                                   clean_busy,
	output core_mem_pkg::mem_req_t                 clean_req,
	output logic                                   clean_done
);
	import core_mem_pkg::*;

	localparam int CNT_W = $clog2(KV_USER_DEPTH);

	logic start;
	logic last;
	logic [USER_ID_WIDTH-1:0] user_q;
	logic [CNT_W-1:0] cnt;

	// requests for users outside the cache are ignored
	assign start = clean_kv_cache && !clean_busy && (clean_user_id < NUM_USERS);
	assign last = clean_busy && (cnt == CNT_W'(KV_USER_DEPTH - 1));

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			clean_busy <= 1'b0;
			clean_done <= 1'b0;
			user_q <= '0;
			cnt <= '0;
		end else begin
			clean_done <= last;
			if (start) begin
				clean_busy <= 1'b1;
				user_q <= clean_user_id;
				cnt <= '0;
			end else if (last) begin
				clean_busy <= 1'b0;
				cnt <= '0;
			end else if (clean_busy) begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	// full-line zero write, one entry per cycle
	always_comb begin
		clean_req.wen = clean_busy;
		clean_req.ren = 1'b0;
		clean_req.addr = line_addr_t'(user_q * KV_USER_DEPTH + cnt);
		clean_req.wdata = '0;
		clean_req.bwe = '1;
	end

endmodule

//--- kv_cache.sv
`timescale 1ns/100ps

module kv_cache #(
	parameter int KV_USER_DEPTH = 64,
	parameter int NUM_USERS = 4
) (
	input  logic                                   clk,
	input  logic                                   rstn,
	input  logic [core_mem_pkg::USER_ID_WIDTH-1:0] user_id,
	input  logic                                   core_wen,
	input  core_mem_pkg::cmem_addr_u               core_waddr,
	input  core_mem_pkg::line_t                    core_wdata,
	input  logic                                   core_ren,
	input  core_mem_pkg::cmem_addr_u               core_raddr,
	input  core_mem_pkg::mem_req_t                 host_req,
	input  logic                                   clean_kv_cache,
	input  logic [core_mem_pkg::USER_ID_WIDTH-1:0] clean_user_id,
	output logic                                   clean_done,
	output core_mem_pkg::line_t                    rdata
);
	import core_mem_pkg::*;

	// user base plus entry, entry wraps within one user region
	function automatic line_addr_t user_line(
		input logic [USER_ID_WIDTH-1:0] uid,
		input logic [KV_ENTRY_WIDTH-1:0] entry
	);
		user_line = line_addr_t'(uid * KV_USER_DEPTH + entry % KV_USER_DEPTH);
	endfunction

	logic clean_busy;
	mem_req_t clean_req;
	line_t lane_data;
	line_t lane_bwe;
	logic map_wen;
	line_addr_t map_addr;
	line_t map_wdata;
	line_t map_bwe;
	mem_req_t core_wr_req;
	mem_req_t core_rd_req;
	mem_req_t sram_req;

	kv_clean_seq #(
		.KV_USER_DEPTH(KV_USER_DEPTH),
		.NUM_USERS    (NUM_USERS)
	) u_clean (
		.clk           (clk),
		.rstn          (rstn),
		.clean_kv_cache(clean_kv_cache),
		.clean_user_id (clean_user_id),
		.clean_busy    (clean_busy),
		.clean_req     (clean_req),
		.clean_done    (clean_done)
	);

	// low byte of the core data lands in the addressed lane
	always_comb begin
		lane_data = '0;
		lane_bwe = '0;
		lane_data[core_waddr.kv.bank*IDATA_WIDTH +: IDATA_WIDTH] = core_wdata[IDATA_WIDTH-1:0];
		lane_bwe[core_waddr.kv.bank*IDATA_WIDTH +: IDATA_WIDTH] = '1;
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			map_wen <= 1'b0;
		end else begin
			map_wen <= core_wen;
		end
	end

	always_ff @(posedge clk) begin
		if (core_wen) begin
			map_addr <= user_line(user_id, core_waddr.kv.entry);
			map_wdata <= lane_data;
			map_bwe <= lane_bwe;
		end
	end

	always_comb begin
		core_wr_req.wen = map_wen;
		core_wr_req.ren = 1'b0;
		core_wr_req.addr = map_addr;
		core_wr_req.wdata = map_wdata;
		core_wr_req.bwe = map_bwe;
		// reads return the whole entry, bank is not looked at
		core_rd_req.wen = 1'b0;
		core_rd_req.ren = core_ren;
		core_rd_req.addr = user_line(user_id, core_raddr.kv.entry);
		core_rd_req.wdata = '0;
		core_rd_req.bwe = '0;
	end

	// clean first, then host, then the core write and read
	always_comb begin
		if (clean_busy) begin
			sram_req = clean_req;
		end else if (host_req.wen || host_req.ren) begin
			sram_req = host_req;
		end else if (map_wen) begin
			sram_req = core_wr_req;
		end else begin
			sram_req = core_rd_req;
		end
	end

	sram_sp #(
		.DEPTH(NUM_USERS * KV_USER_DEPTH)
	) u_sram (
		.clk  (clk),
		.req  (sram_req),
		.rdata(rdata)
	);

endmodule

//--- core_mem.sv
`timescale 1ns/100ps

module core_mem #(
	parameter int WMEM_DEPTH = 256,
	parameter int KV_USER_DEPTH = 64,
	parameter int NUM_USERS = 4
) (
	input  logic                                     clk,
	input  logic                                     rstn,
	input  logic [core_mem_pkg::HOST_ADDR_WIDTH-1:0] host_addr,
	input  core_mem_pkg::host_word_t                 host_wdata,
	input  logic                                     host_wen,
	input  logic                                     host_ren,
	output core_mem_pkg::host_word_t                 host_rdata,
	output logic                                     host_rvld,
	input  logic [core_mem_pkg::CMEM_ADDR_WIDTH-1:0] cmem_waddr,
	input  logic                                     cmem_wen,
	input  core_mem_pkg::line_t                      cmem_wdata,
	input  logic [core_mem_pkg::CMEM_ADDR_WIDTH-1:0] cmem_raddr,
	input  logic                                     cmem_ren,
	output core_mem_pkg::line_t                      cmem_rdata,
	output logic                                     cmem_rvalid,
	input  logic [core_mem_pkg::USER_ID_WIDTH-1:0]   user_id,
	input  logic                                     clean_kv_cache,
	input  logic [core_mem_pkg::USER_ID_WIDTH-1:0]   clean_user_id,
	output logic                                     clean_done
);
	import core_mem_pkg::*;

	cmem_addr_u waddr_u;
	cmem_addr_u raddr_u;
	mem_req_t wmem_host_req;
	mem_req_t kv_host_req;
	mem_req_t weight_core_req;
	line_t wmem_rdata;
	line_t kv_rdata;
	logic wgt_wen;
	logic wgt_ren;
	logic kv_wen;
	logic kv_ren;
	logic rd_wgt_q;
	logic rd_kv_q;

	assign waddr_u = cmem_waddr;
	assign raddr_u = cmem_raddr;

	// region bit set means kv cache
	always_comb begin
		wgt_wen = cmem_wen && !waddr_u.wgt.kv;
		wgt_ren = cmem_ren && !raddr_u.wgt.kv;
		kv_wen = cmem_wen && waddr_u.kv.kv;
		kv_ren = cmem_ren && raddr_u.kv.kv;
		// single address, so a write pushes a read out
		weight_core_req.wen = wgt_wen;
		weight_core_req.ren = wgt_ren && !wgt_wen;
		if (wgt_wen) begin
			weight_core_req.addr = line_addr_t'(waddr_u.wgt.line);
		end else begin
			weight_core_req.addr = line_addr_t'(raddr_u.wgt.line);
		end
		weight_core_req.wdata = cmem_wdata;
		weight_core_req.bwe = '1;
	end

	host_bridge u_host (
		.clk            (clk),
		.rstn           (rstn),
		.host_addr      (host_addr),
		.host_wdata     (host_wdata),
		.host_wen       (host_wen),
		.host_ren       (host_ren),
		.wmem_host_req  (wmem_host_req),
		.kv_host_req    (kv_host_req),
		.wmem_host_rdata(wmem_rdata),
		.kv_cache_rdata (kv_rdata),
		.host_rdata     (host_rdata),
		.host_rvld      (host_rvld)
	);

	weight_mem #(
		.DEPTH(WMEM_DEPTH)
	) u_wmem (
		.clk     (clk),
		.host_req(wmem_host_req),
		.core_req(weight_core_req),
		.rdata   (wmem_rdata)
	);

	kv_cache #(
		.KV_USER_DEPTH(KV_USER_DEPTH),
		.NUM_USERS    (NUM_USERS)
	) u_kv (
		.clk           (clk),
		.rstn          (rstn),
		.user_id       (user_id),
		.core_wen      (kv_wen),
		.core_waddr    (waddr_u),
		.core_wdata    (cmem_wdata),
		.core_ren      (kv_ren),
		.core_raddr    (raddr_u),
		.host_req      (kv_host_req),
		.clean_kv_cache(clean_kv_cache),
		.clean_user_id (clean_user_id),
		.clean_done    (clean_done),
		.rdata         (kv_rdata)
	);

	// remember which memory answers the read
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			rd_wgt_q <= 1'b0;
			rd_kv_q <= 1'b0;
		end else begin
			rd_wgt_q <= weight_core_req.ren;
			rd_kv_q <= kv_ren;
		end
	end

	always_comb begin
		cmem_rvalid = rd_wgt_q || rd_kv_q;
		if (rd_kv_q) begin
			cmem_rdata = kv_rdata;
		end else if (rd_wgt_q) begin
			cmem_rdata = wmem_rdata;
		end else begin
			cmem_rdata = '0;
		end
	end

endmodule

//--- tb_core_mem.sv
`timescale 1ns/100ps

module tb_core_mem;
	import core_mem_pkg::*;

	localparam int WMEM_DEPTH = 256;
	localparam int KV_USER_DEPTH = 64;
	localparam int NUM_USERS = 4;
	localparam int IDLE_CYCLES = 2;
	localparam int WAIT_LIMIT = 200;
	localparam int HOST_MID_W = HOST_ADDR_WIDTH - HOST_REGION_WIDTH - WORD_SEL_WIDTH;
	localparam int WGT_LINE_W = CMEM_ADDR_WIDTH - 1;

	typedef enum logic [2:0] {
		OP_HWR,
		OP_HRD,
		OP_CWR,
		OP_CRD,
		OP_CLEAN,
		OP_USER
	} op_e;

	// one stimulus step and the value it should produce
	typedef struct packed {
		op_e                        op;
		logic [HOST_ADDR_WIDTH-1:0] addr;
		line_t                      data;
		line_t                      want;
	} row_t;

	logic clk = 1'b0;
	logic rstn;
	logic [HOST_ADDR_WIDTH-1:0] host_addr;
	host_word_t host_wdata;
	logic host_wen;
	logic host_ren;
	host_word_t host_rdata;
	logic host_rvld;
	logic [CMEM_ADDR_WIDTH-1:0] cmem_waddr;
	logic cmem_wen;
	line_t cmem_wdata;
	logic [CMEM_ADDR_WIDTH-1:0] cmem_raddr;
	logic cmem_ren;
	line_t cmem_rdata;
	logic cmem_rvalid;
	logic [USER_ID_WIDTH-1:0] user_id;
	logic clean_kv_cache;
	logic [USER_ID_WIDTH-1:0] clean_user_id;
	logic clean_done;

	row_t rows_q[$];
	logic [15:0] lfsr_state = 16'd62883;

	always #2 clk = ~clk;

	core_mem #(
		.WMEM_DEPTH   (WMEM_DEPTH),
		.KV_USER_DEPTH(KV_USER_DEPTH),
		.NUM_USERS    (NUM_USERS)
	) dut0 (
		.clk           (clk),
		.rstn          (rstn),
		.host_addr     (host_addr),
		.host_wdata    (host_wdata),
		.host_wen      (host_wen),
		.host_ren      (host_ren),
		.host_rdata    (host_rdata),
		.host_rvld     (host_rvld),
		.cmem_waddr    (cmem_waddr),
		.cmem_wen      (cmem_wen),
		.cmem_wdata    (cmem_wdata),
		.cmem_raddr    (cmem_raddr),
		.cmem_ren      (cmem_ren),
		.cmem_rdata    (cmem_rdata),
		.cmem_rvalid   (cmem_rvalid),
		.user_id       (user_id),
		.clean_kv_cache(clean_kv_cache),
		.clean_user_id (clean_user_id),
		.clean_done    (clean_done)
	);

	// taps 16, 14, 13, 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		lfsr_step = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic draw_word(output host_word_t w);
		w = '0;
		for (int b = 0; b < HOST_DATA_WIDTH; b++) begin
			lfsr_state = lfsr_step(lfsr_state);
			w = {w[HOST_DATA_WIDTH-2:0], lfsr_state[0]};
		end
	endtask

	function automatic logic [HOST_ADDR_WIDTH-1:0] host_address(input int region, input int line,
		input int word);
		host_address = {HOST_REGION_WIDTH'(region), HOST_MID_W'(line), WORD_SEL_WIDTH'(word)};
	endfunction

	function automatic logic [HOST_ADDR_WIDTH-1:0] weight_core_address(input int line);
		weight_core_address = HOST_ADDR_WIDTH'({1'b0, WGT_LINE_W'(line)});
	endfunction

	function automatic logic [HOST_ADDR_WIDTH-1:0] kv_core_address(input int bank, input int entry);
		kv_core_address = HOST_ADDR_WIDTH'({1'b1, LANE_SEL_WIDTH'(bank), KV_ENTRY_WIDTH'(entry)});
	endfunction

	task automatic check_value(input string name, input line_t got, input line_t want);
		if (got !== want) begin
			$display("Error at time %0t: %s = %h, expected %h", $time, name, got, want);
			$display("TEST FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic add_row(input op_e op, input logic [HOST_ADDR_WIDTH-1:0] addr,
		input line_t data, input line_t want);
		row_t r;
		r.op = op;
		r.addr = addr;
		r.data = data;
		r.want = want;
		rows_q.push_back(r);
	endtask

	task automatic build_table();
		line_t wline;
		line_t cline;
		line_t uline;
		line_t lanes;
		host_word_t w;
		int k;
		// weight line 5 filled word by word from the host
		wline = '0;
		for (k = 0; k < WORDS_PER_LINE; k++) begin
			draw_word(w);
			wline[k*HOST_DATA_WIDTH +: HOST_DATA_WIDTH] = w;
			add_row(OP_HWR, host_address(1, 5, k), line_t'(w), '0);
		end
		for (k = 0; k < WORDS_PER_LINE; k++) begin
			add_row(OP_HRD, host_address(1, 5, k), '0, line_t'(wline[k*HOST_DATA_WIDTH +: 16]));
		end
		add_row(OP_CRD, weight_core_address(5), '0, wline);
		// full line from the core, read back by the host
		for (k = 0; k < WORDS_PER_LINE; k++) begin
			draw_word(w);
			cline[k*HOST_DATA_WIDTH +: HOST_DATA_WIDTH] = w;
		end
		add_row(OP_CWR, weight_core_address(9), cline, '0);
		for (k = 0; k < WORDS_PER_LINE; k++) begin
			add_row(OP_HRD, host_address(1, 9, k), '0, line_t'(cline[k*HOST_DATA_WIDTH +: 16]));
		end
		// user 1, entry 10 written through the host
		for (k = 0; k < WORDS_PER_LINE; k++) begin
			draw_word(w);
			uline[k*HOST_DATA_WIDTH +: HOST_DATA_WIDTH] = w;
			add_row(OP_HWR, host_address(0, KV_USER_DEPTH + 10, k), line_t'(w), '0);
		end
		add_row(OP_USER, '0, line_t'(1), '0);
		add_row(OP_CRD, kv_core_address(7, 10), '0, uline);
		// lane writes into a freshly cleared user 2
		add_row(OP_CLEAN, '0, line_t'(2), '0);
		add_row(OP_USER, '0, line_t'(2), '0);
		lanes = '0;
		lanes[0*IDATA_WIDTH +: IDATA_WIDTH] = 8'h5a;
		lanes[5*IDATA_WIDTH +: IDATA_WIDTH] = 8'hc3;
		lanes[15*IDATA_WIDTH +: IDATA_WIDTH] = 8'h7e;
		add_row(OP_CWR, kv_core_address(0, 3), {{15{8'hee}}, 8'h5a}, '0);
		add_row(OP_CWR, kv_core_address(5, 3), {{15{8'h11}}, 8'hc3}, '0);
		add_row(OP_CWR, kv_core_address(15, 3), {{15{8'h99}}, 8'h7e}, '0);
		add_row(OP_CRD, kv_core_address(0, 3), '0, lanes);
		for (k = 0; k < WORDS_PER_LINE; k++) begin
			add_row(OP_HRD, host_address(0, 2 * KV_USER_DEPTH + 3, k), '0,
				line_t'(lanes[k*HOST_DATA_WIDTH +: 16]));
		end
		// clean user 2 again, user 1 must survive
		add_row(OP_CLEAN, '0, line_t'(2), '0);
		add_row(OP_CRD, kv_core_address(0, 3), '0, '0);
		add_row(OP_USER, '0, line_t'(1), '0);
		add_row(OP_CRD, kv_core_address(0, 10), '0, uline);
	endtask

	// sel 0 host read valid, 1 core read valid, 2 clean done
	task automatic wait_for_pulse(input int sel, input int lat_want, input string what);
		int lat;
		logic seen;
		lat = 1;
		seen = 1'b0;
		while (!seen) begin
			@(negedge clk);
			case (sel)
				0: seen = host_rvld;
				1: seen = cmem_rvalid;
				default: seen = clean_done;
			endcase
			if (!seen) begin
				if (lat >= WAIT_LIMIT) begin
					$display("no %s pulse arrived within %0d cycles", what, WAIT_LIMIT);
					$display("TEST FAILED");
					$fatal(1, "timeout");
				end else begin
					@(posedge clk);
					lat++;
				end
			end
		end
		check_value({what, " latency"}, line_t'(lat), line_t'(lat_want));
	endtask

	task automatic apply_row(input row_t r);
		@(posedge clk);
		case (r.op)
			OP_HWR: begin
				host_addr <= r.addr;
				host_wdata <= r.data[HOST_DATA_WIDTH-1:0];
				host_wen <= 1'b1;
			end
			OP_HRD: begin
				host_addr <= r.addr;
				host_ren <= 1'b1;
			end
			OP_CWR: begin
				cmem_waddr <= r.addr[CMEM_ADDR_WIDTH-1:0];
				cmem_wdata <= r.data;
				cmem_wen <= 1'b1;
			end
			OP_CRD: begin
				cmem_raddr <= r.addr[CMEM_ADDR_WIDTH-1:0];
				cmem_ren <= 1'b1;
			end
			OP_CLEAN: begin
				clean_user_id <= r.data[USER_ID_WIDTH-1:0];
				clean_kv_cache <= 1'b1;
			end
			default: user_id <= r.data[USER_ID_WIDTH-1:0];
		endcase
		@(posedge clk);
		host_wen <= 1'b0;
		host_ren <= 1'b0;
		cmem_wen <= 1'b0;
		cmem_ren <= 1'b0;
		clean_kv_cache <= 1'b0;
		case (r.op)
			OP_HRD: begin
				wait_for_pulse(0, 2, "host read valid");
				check_value("host_rdata", line_t'(host_rdata), r.want);
			end
			OP_CRD: begin
				wait_for_pulse(1, 1, "core read valid");
				check_value("cmem_rdata", cmem_rdata, r.want);
			end
			OP_CLEAN: wait_for_pulse(2, KV_USER_DEPTH + 1, "clean done");
			default: ;
		endcase
		repeat (IDLE_CYCLES) @(posedge clk);
	endtask

	initial begin
		rstn = 1'b0;
		host_addr = '0;
		host_wdata = '0;
		host_wen = 1'b0;
		host_ren = 1'b0;
		cmem_waddr = '0;
		cmem_wen = 1'b0;
		cmem_wdata = '0;
		cmem_raddr = '0;
		cmem_ren = 1'b0;
		user_id = '0;
		clean_kv_cache = 1'b0;
		clean_user_id = '0;
		build_table();
		repeat (3) @(posedge clk);
		rstn <= 1'b1;
		// outputs idle straight after reset
		@(negedge clk);
		check_value("host_rvld", line_t'(host_rvld), '0);
		check_value("cmem_rvalid", line_t'(cmem_rvalid), '0);
		check_value("clean_done", line_t'(clean_done), '0);
		check_value("cmem_rdata", cmem_rdata, '0);
		foreach (rows_q[i]) begin
			apply_row(rows_q[i]);
		end
		$display("TEST OK");
		$finish;
	end

endmodule

//--- list.f
core_mem_pkg.sv
sram_sp.sv
host_bridge.sv
weight_mem.sv
kv_clean_seq.sv
kv_cache.sv
core_mem.sv
tb_core_mem.sv

//--- Bender.yml
package:
  name: core_mem

sources:
  - core_mem_pkg.sv
  - sram_sp.sv
  - host_bridge.sv
  - weight_mem.sv
  - kv_clean_seq.sv
  - kv_cache.sv
  - core_mem.sv
  - target: simulation
    files:
      - tb_core_mem.sv
